/* flist.f */
verilog/decoder_pkg.sv
verilog/csr_decode.sv
verilog/csr.sv
verilog/csr_file.sv
verilog/csr_writeback.sv
verilog/csr_unit.sv
tb/csr_unit_tb.sv

/* tb/csr_unit_tb.sv */
// csr unit testbench

`timescale 1ns/1ps

module csr_unit_tb;
  import decoder_pkg::*;

  localparam int MAX_ENTRIES = 40;
  localparam int TIMEOUT_CYCLES = 20;
  localparam logic [6:0] OPCODE_OP = 7'h33;

  logic clk;
  logic reset;
  word instr;
  logic instr_valid;
  word rs1_data;
  logic rd_valid;
  r rd;
  word rd_data;
  logic illegal;

  integer seed;

  // stimulus table, one column per array
  string t_name [MAX_ENTRIES];
  logic [6:0] t_opcode [MAX_ENTRIES];
  csr_op_t t_op [MAX_ENTRIES];
  csr_addr_t t_addr [MAX_ENTRIES];
  r t_src [MAX_ENTRIES];
  r t_rd [MAX_ENTRIES];
  word t_rs1 [MAX_ENTRIES];
  bit t_bad [MAX_ENTRIES];
  int num_entries;

  // model of mscratch, mtvec, mcause
  word model [3];
  word last_cycle;
  bit have_cycle;
  word expected;
  int i;

  csr_unit csr_unit_inst (
    .clk(clk),
    .reset(reset),
    .instr(instr),
    .instr_valid(instr_valid),
    .rs1_data(rs1_data),
    .rd_valid(rd_valid),
    .rd(rd),
    .rd_data(rd_data),
    .illegal(illegal)
  );

  always #4 clk = ~clk;

  task automatic add_entry(input string name, input logic [6:0] opcode, input csr_op_t op,
                           input csr_addr_t addr, input r src, input r rd_idx,
                           input word rs1v, input bit bad);
    t_name[num_entries] = name;
    t_opcode[num_entries] = opcode;
    t_op[num_entries] = op;
    t_addr[num_entries] = addr;
    t_src[num_entries] = src;
    t_rd[num_entries] = rd_idx;
    t_rs1[num_entries] = rs1v;
    t_bad[num_entries] = bad;
    num_entries++;
  endtask

  // i-type layout of a system instruction
  function automatic word encode(input logic [6:0] opcode, input csr_op_t op,
                                 input csr_addr_t addr, input r src, input r rd_idx);
    return {addr, src, op, rd_idx, opcode};
  endfunction

  function automatic word model_value(input csr_addr_t addr);
    case (addr)
      ADDR_MSCRATCH: return model[0];
      ADDR_MTVEC: return model[1];
      ADDR_MCAUSE: return model[2];
      default: return 32'h0;
    endcase
  endfunction

  task automatic update_model(input int idx);
    word src;
    word next;
    bit writes;
    src = t_op[idx][2] ? {27'b0, t_src[idx]} : t_rs1[idx];
    writes = (t_op[idx] == CSRRW) || (t_op[idx] == CSRRWI) || (t_src[idx] != 5'd0);
    case (t_op[idx])
      CSRRW, CSRRWI: next = src;
      CSRRS, CSRRSI: next = model_value(t_addr[idx]) | src;
      default: next = model_value(t_addr[idx]) & ~src;
    endcase
    if (writes) begin
      case (t_addr[idx])
        ADDR_MSCRATCH: model[0] = next;
        ADDR_MTVEC: model[1] = next;
        // only the low cause bits exist
        ADDR_MCAUSE: model[2] = next & ((32'd1 << MCAUSE_WIDTH) - 1);
        default: ;
      endcase
    end
  endtask

  task automatic check_word(input string name, input word exp, input word act);
    if (exp !== act) begin
      $display("MISMATCH %s rd_data: expected %08h actual %08h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "data compare failed");
    end
  endtask

  task automatic check_r(input string name, input r exp, input r act);
    if (exp !== act) begin
      $display("MISMATCH %s rd: expected %0d actual %0d", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "register index compare failed");
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %b actual %b", name, what, exp, act);
      $display("TEST FAILED");
      $fatal(1, "flag compare failed");
    end
  endtask

  // sample at the falling edge, away from the update
  task automatic wait_for_result(input string name);
    int count;
    count = 0;
    do begin
      @(negedge clk);
      count++;
    end while (!(rd_valid || illegal) && count < TIMEOUT_CYCLES);
    if (!(rd_valid || illegal)) begin
      $display("no rd_valid or illegal from the DUT for %s", name);
      $display("TEST FAILED");
      $fatal(1, "result wait timed out");
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    instr = '0;
    instr_valid = 1'b0;
    rs1_data = '0;
    seed = 32'h9d19_4689;
    num_entries = 0;
    model[0] = 32'h0;
    model[1] = MTVEC_RESET;
    model[2] = 32'h0;
    have_cycle = 1'b0;
    last_cycle = '0;

    // reset values, read through csrrs x0
    add_entry("rst_mscratch", OPCODE_SYSTEM, CSRRS, ADDR_MSCRATCH, 5'd0, 5'd1, $random(seed), 0);
    add_entry("rst_mtvec", OPCODE_SYSTEM, CSRRS, ADDR_MTVEC, 5'd0, 5'd2, $random(seed), 0);
    add_entry("rst_mcause", OPCODE_SYSTEM, CSRRS, ADDR_MCAUSE, 5'd0, 5'd3, $random(seed), 0);
    add_entry("rst_mhartid", OPCODE_SYSTEM, CSRRS, ADDR_MHARTID, 5'd0, 5'd4, $random(seed), 0);
    add_entry("cycle_a", OPCODE_SYSTEM, CSRRS, ADDR_CYCLE, 5'd0, 5'd5, '0, 0);
    // register forms on mscratch
    add_entry("rw_mscratch", OPCODE_SYSTEM, CSRRW, ADDR_MSCRATCH, 5'd7, 5'd6, $random(seed), 0);
    add_entry("rs_mscratch", OPCODE_SYSTEM, CSRRS, ADDR_MSCRATCH, 5'd8, 5'd0, $random(seed), 0);
    add_entry("rc_mscratch", OPCODE_SYSTEM, CSRRC, ADDR_MSCRATCH, 5'd9, 5'd10, $random(seed), 0);
    add_entry("rd_mscratch", OPCODE_SYSTEM, CSRRS, ADDR_MSCRATCH, 5'd0, 5'd11, '0, 0);
    // immediate forms on mtvec, rs1 data must be ignored
    add_entry("rwi_mtvec", OPCODE_SYSTEM, CSRRWI, ADDR_MTVEC, r'($random(seed)), 5'd12,
              $random(seed), 0);
    add_entry("rsi_mtvec", OPCODE_SYSTEM, CSRRSI, ADDR_MTVEC, r'($random(seed)), 5'd13,
              $random(seed), 0);
    add_entry("rci_mtvec", OPCODE_SYSTEM, CSRRCI, ADDR_MTVEC, r'($random(seed)), 5'd14,
              $random(seed), 0);
    add_entry("rsi0_mtvec", OPCODE_SYSTEM, CSRRSI, ADDR_MTVEC, 5'd0, 5'd15, $random(seed), 0);
    add_entry("rci0_mtvec", OPCODE_SYSTEM, CSRRCI, ADDR_MTVEC, 5'd0, 5'd16, $random(seed), 0);
    add_entry("rd_mtvec", OPCODE_SYSTEM, CSRRS, ADDR_MTVEC, 5'd0, 5'd17, '0, 0);
    // narrow mcause
    add_entry("rw_mcause", OPCODE_SYSTEM, CSRRW, ADDR_MCAUSE, 5'd18, 5'd18, $random(seed), 0);
    add_entry("rd_mcause", OPCODE_SYSTEM, CSRRS, ADDR_MCAUSE, 5'd0, 5'd19, '0, 0);
    // illegal forms, each followed by a read
    add_entry("bad_addr", OPCODE_SYSTEM, CSRRW, 12'h7C0, 5'd3, 5'd20, $random(seed), 1);
    add_entry("after_addr", OPCODE_SYSTEM, CSRRS, ADDR_MSCRATCH, 5'd0, 5'd21, '0, 0);
    add_entry("bad_funct3", OPCODE_SYSTEM, 3'd4, ADDR_MSCRATCH, 5'd4, 5'd22, $random(seed), 1);
    add_entry("after_funct3", OPCODE_SYSTEM, CSRRS, ADDR_MSCRATCH, 5'd0, 5'd23, '0, 0);
    add_entry("bad_opcode", OPCODE_OP, CSRRW, ADDR_MTVEC, 5'd5, 5'd24, $random(seed), 1);
    add_entry("after_opcode", OPCODE_SYSTEM, CSRRS, ADDR_MTVEC, 5'd0, 5'd25, '0, 0);
    add_entry("cycle_b", OPCODE_SYSTEM, CSRRSI, ADDR_CYCLE, 5'd0, 5'd26, '0, 0);
    add_entry("rw_mhartid", OPCODE_SYSTEM, CSRRW, ADDR_MHARTID, 5'd6, 5'd27, $random(seed), 1);
    add_entry("after_mhartid", OPCODE_SYSTEM, CSRRS, ADDR_MHARTID, 5'd0, 5'd28, '0, 0);
    add_entry("rw_cycle", OPCODE_SYSTEM, CSRRW, ADDR_CYCLE, 5'd7, 5'd29, $random(seed), 1);
    add_entry("cycle_c", OPCODE_SYSTEM, CSRRS, ADDR_CYCLE, 5'd0, 5'd30, '0, 0);
    add_entry("rd_mcause_end", OPCODE_SYSTEM, CSRRS, ADDR_MCAUSE, 5'd0, 5'd31, '0, 0);
    add_entry("cycle_d", OPCODE_SYSTEM, CSRRS, ADDR_CYCLE, 5'd0, 5'd1, '0, 0);

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    for (i = 0; i < num_entries; i++) begin
      @(posedge clk);
      instr <= encode(t_opcode[i], t_op[i], t_addr[i], t_src[i], t_rd[i]);
      rs1_data <= t_rs1[i];
      instr_valid <= 1'b1;
      @(posedge clk);
      instr_valid <= 1'b0;
      wait_for_result(t_name[i]);
      check_flag(t_name[i], "illegal", t_bad[i], illegal);
      check_flag(t_name[i], "rd_valid", !t_bad[i], rd_valid);
      if (!t_bad[i]) begin
        check_r(t_name[i], t_rd[i], rd);
        if (t_addr[i] == ADDR_CYCLE) begin
          if (have_cycle && rd_data <= last_cycle) begin
            $display("cycle did not increase at %s: %0d after %0d", t_name[i], rd_data,
                     last_cycle);
            $display("TEST FAILED");
            $fatal(1, "cycle counter stalled");
          end
          last_cycle = rd_data;
          have_cycle = 1'b1;
        end else begin
          expected = model_value(t_addr[i]);
          check_word(t_name[i], expected, rd_data);
          update_model(i);
        end
      end
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

/* verilog/csr_unit.sv */
// csr unit top level

`timescale 1ns/1ps

module csr_unit (
  input logic clk,
  input logic reset,
  input decoder_pkg::word instr,
  input logic instr_valid,
  input decoder_pkg::word rs1_data,
  output logic rd_valid,
  output decoder_pkg::r rd,
  output decoder_pkg::word rd_data,
  output logic illegal
);
  import decoder_pkg::*;

  // decode to execute
  logic csr_enable;
  csr_addr_t csr_addr;
  csr_op_t csr_op;
  r rs1_zimm;
  logic csr_write;

  // decode and execute to result
  r rd_dec;
  logic decode_illegal;
  word read_data;
  logic csr_illegal;

  csr_decode csr_decode_inst (
    .instr(instr),
    .instr_valid(instr_valid),
    .csr_enable(csr_enable),
    .csr_addr(csr_addr),
    .csr_op(csr_op),
    .rs1_zimm(rs1_zimm),
    .csr_write(csr_write),
    .rd(rd_dec),
    .decode_illegal(decode_illegal)
  );

  csr_file csr_file_inst (
    .clk(clk),
    .reset(reset),
    .csr_enable(csr_enable),
    .csr_addr(csr_addr),
    .csr_op(csr_op),
    .csr_write(csr_write),
    .rs1_zimm(rs1_zimm),
    .rs1_data(rs1_data),
    .read_data(read_data),
    .csr_illegal(csr_illegal)
  );

  csr_writeback csr_writeback_inst (
    .clk(clk),
    .reset(reset),
    .csr_enable(csr_enable),
    .decode_illegal(decode_illegal),
    .csr_illegal(csr_illegal),
    .rd(rd_dec),
    .read_data(read_data),
    .rd_valid(rd_valid),
    .rd_out(rd),
    .rd_data(rd_data),
    .illegal(illegal)
  );

endmodule

/* verilog/csr_writeback.sv */
// csr result stage

`timescale 1ns/1ps

module csr_writeback (
  input logic clk,
  input logic reset,
  input logic csr_enable,
  input logic decode_illegal,
  input logic csr_illegal,
  input decoder_pkg::r rd,
  input decoder_pkg::word read_data,
  output logic rd_valid,
  output decoder_pkg::r rd_out,
  output decoder_pkg::word rd_data,
  output logic illegal
);

  logic access_ok;
  logic access_bad;

  // legal access, x0 included, the core drops that write
  assign access_ok = csr_enable && !csr_illegal;

  // bad encoding or bad register access
  assign access_bad = decode_illegal || (csr_enable && csr_illegal);

  // one-cycle result strobes
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
      illegal <= 1'b0;
    end else begin
      rd_valid <= access_ok;
      illegal <= access_bad;
    end
  end

  // old csr value, taken before the bank updates
  always_ff @(posedge clk) begin
    if (csr_enable) begin
      rd_out <= rd;
      rd_data <= read_data;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(rd_valid && illegal));

endmodule

/* verilog/csr_file.sv */
// csr bank and execute stage

`timescale 1ns/1ps

module csr_file (
  input logic clk,
  input logic reset,
  input logic csr_enable,
  input decoder_pkg::csr_addr_t csr_addr,
  input decoder_pkg::csr_op_t csr_op,
  input logic csr_write,
  input decoder_pkg::r rs1_zimm,
  input decoder_pkg::word rs1_data,
  output decoder_pkg::word read_data,
  output logic csr_illegal
);
  import decoder_pkg::*;

  word mscratch_out;
  word mtvec_out;
  word mcause_out;
  word mhartid_out;
  word cycle_out;
  logic hit_mscratch;
  logic hit_mtvec;
  logic hit_mcause;
  logic hit_mhartid;
  logic hit_cycle;
  logic [4:0] hits;
  logic ro_hit;
  word cycle_count;

  // free-running counter, wraps at 32 bits
  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 32'd1;
    end
  end

  csr #(.CsrWidth(32), .ResetValue(32'h0), .Addr(ADDR_MSCRATCH), .Read(1'b1), .Write(1'b1))
  mscratch_inst (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .csr_write, .rs1_zimm, .rs1_data,
    .ext_data('0), .ext_write_enable(1'b0), .out(mscratch_out), .hit(hit_mscratch)
  );

  csr #(.CsrWidth(32), .ResetValue(MTVEC_RESET), .Addr(ADDR_MTVEC), .Read(1'b1), .Write(1'b1))
  mtvec_inst (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .csr_write, .rs1_zimm, .rs1_data,
    .ext_data('0), .ext_write_enable(1'b0), .out(mtvec_out), .hit(hit_mtvec)
  );

  // narrow cause code, upper bits read back as zero
  csr #(.CsrWidth(MCAUSE_WIDTH), .ResetValue('0), .Addr(ADDR_MCAUSE), .Read(1'b1), .Write(1'b1))
  mcause_inst (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .csr_write, .rs1_zimm, .rs1_data,
    .ext_data('0), .ext_write_enable(1'b0), .out(mcause_out), .hit(hit_mcause)
  );

  // single hart, id fixed at zero
  csr #(.CsrWidth(32), .ResetValue(32'h0), .Addr(ADDR_MHARTID), .Read(1'b1), .Write(1'b0))
  mhartid_inst (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .csr_write, .rs1_zimm, .rs1_data,
    .ext_data('0), .ext_write_enable(1'b0), .out(mhartid_out), .hit(hit_mhartid)
  );

  // loaded from the counter every clock
  csr #(.CsrWidth(32), .ResetValue(32'h0), .Addr(ADDR_CYCLE), .Read(1'b1), .Write(1'b0))
  cycle_inst (
    .clk, .reset, .csr_enable, .csr_addr, .csr_op, .csr_write, .rs1_zimm, .rs1_data,
    .ext_data(cycle_count), .ext_write_enable(1'b1), .out(cycle_out), .hit(hit_cycle)
  );

  // unselected registers drive zero
  assign read_data = mscratch_out | mtvec_out | mcause_out | mhartid_out | cycle_out;

  assign hits = {hit_cycle, hit_mhartid, hit_mcause, hit_mtvec, hit_mscratch};
  assign ro_hit = hit_mhartid | hit_cycle;

  // unknown address, or a write to a read-only register
  assign csr_illegal = csr_enable && ((hits == '0) || (csr_write && ro_hit));

  // addresses decode to at most one register
  assert property (@(posedge clk) disable iff (reset) $onehot0(hits));

endmodule

/* verilog/csr.sv */
// single control and status register

`timescale 1ns/1ps

module csr #(
  parameter int unsigned CsrWidth = 32,
  parameter logic [CsrWidth-1:0] ResetValue = '0,
  parameter decoder_pkg::csr_addr_t Addr = '0,
  parameter bit Read = 1'b1,
  parameter bit Write = 1'b1
) (
  input logic clk,
  input logic reset,
  input logic csr_enable,
  input decoder_pkg::csr_addr_t csr_addr,
  input decoder_pkg::csr_op_t csr_op,
  input logic csr_write,
  input decoder_pkg::r rs1_zimm,
  input decoder_pkg::word rs1_data,
  input logic [CsrWidth-1:0] ext_data,
  input logic ext_write_enable,
  output decoder_pkg::word out,
  output logic hit
);
  import decoder_pkg::*;

  typedef logic [CsrWidth-1:0] csr_data_t;

  csr_data_t data;
  logic addr_match;
  logic imm_form;
  logic access_write;
  word operand;
  csr_data_t operand_trunc;

  assign addr_match = (csr_addr == Addr);
  assign hit = csr_enable && addr_match;

  // asynchronous read, zero-extended to a word
  assign out = (Read && addr_match) ? word'(data) : '0;

  // immediate forms take zimm in place of rs1 data
  assign imm_form = (csr_op == CSRRWI) || (csr_op == CSRRSI) || (csr_op == CSRRCI);
  assign operand = imm_form ? word'(rs1_zimm) : rs1_data;

  // narrow registers keep only the low bits
  assign operand_trunc = csr_data_t'(operand);

  // read-only registers never take an instruction write
  assign access_write = hit && Write && csr_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      data <= ResetValue;
    end else if (ext_write_enable) begin
      // side-effect path wins over the instruction
      data <= ext_data;
    end else if (access_write) begin
      case (csr_op)
        CSRRW, CSRRWI: data <= operand_trunc;
        CSRRS, CSRRSI: data <= data | operand_trunc;
        CSRRC, CSRRCI: data <= data & ~operand_trunc;
        default: data <= data;
      endcase
    end
  end

  // a read-only register moves only through its external port
  assert property (@(posedge clk) disable iff (reset)
    (!Write && !ext_write_enable) |=> (data == $past(data)));

endmodule

/* verilog/csr_decode.sv */
// csr instruction decoder

`timescale 1ns/1ps

module csr_decode (
  input decoder_pkg::word instr,
  input logic instr_valid,
  output logic csr_enable,
  output decoder_pkg::csr_addr_t csr_addr,
  output decoder_pkg::csr_op_t csr_op,
  output decoder_pkg::r rs1_zimm,
  output logic csr_write,
  output decoder_pkg::r rd,
  output logic decode_illegal
);
  import decoder_pkg::*;

  logic [6:0] opcode;
  logic opcode_ok;
  logic funct3_ok;
  logic decode_legal;
  logic always_writes;

  // i-type field slices
  assign opcode = instr[6:0];
  assign rd = instr[11:7];
  assign csr_op = instr[14:12];
  assign rs1_zimm = instr[19:15];
  assign csr_addr = instr[31:20];

  assign opcode_ok = (opcode == OPCODE_SYSTEM);

  // funct3 0 is ecall/ebreak space, 4 is unassigned
  assign funct3_ok = (csr_op != 3'd0) && (csr_op != 3'd4);

  assign decode_legal = opcode_ok && funct3_ok;

  assign csr_enable = instr_valid && decode_legal;
  assign decode_illegal = instr_valid && !decode_legal;

  // rw forms write even with x0 / zimm 0
  assign always_writes = (csr_op == CSRRW) || (csr_op == CSRRWI);

  // set and clear with a zero source only read
  // decided once here for all later stages
  assign csr_write = always_writes || (rs1_zimm != '0);

  // enable and illegal never overlap
  always_comb begin
    assert final (!(csr_enable && decode_illegal));
  end

endmodule

/* verilog/decoder_pkg.sv */
// csr unit shared definitions

package decoder_pkg;

  // data path word, also the instruction width
  typedef logic [31:0] word;

  // register index or zimm immediate
  typedef logic [4:0] r;

  // csr address field of the instruction
  typedef logic [11:0] csr_addr_t;

  // funct3 field selecting the zicsr operation
  typedef logic [2:0] csr_op_t;

  // funct3 operation codes
  // bit 2 selects the immediate form
  localparam csr_op_t CSRRW = 3'd1;
  localparam csr_op_t CSRRS = 3'd2;
  localparam csr_op_t CSRRC = 3'd3;
  localparam csr_op_t CSRRWI = 3'd5;
  localparam csr_op_t CSRRSI = 3'd6;
  localparam csr_op_t CSRRCI = 3'd7;

  // major opcode of csr instructions
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;

  // machine mode registers
  localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
  localparam csr_addr_t ADDR_MTVEC = 12'h305;
  localparam csr_addr_t ADDR_MCAUSE = 12'h342;
  localparam csr_addr_t ADDR_MHARTID = 12'hF14;

  // user counter, read-only here
  localparam csr_addr_t ADDR_CYCLE = 12'hC00;

  // trap vector after reset
  localparam word MTVEC_RESET = 32'h0000_0100;

  // implemented bits of mcause
  // upper bits read as zero
  localparam int unsigned MCAUSE_WIDTH = 5;

endpackage
